/* sim/cnu_stim.dat */
# Columns: name, then five beats of (gap msg_0 msg_1), then expected messages p0 to p9
# gap is idle cycles before the beat in decimal, messages are 4-bit hex

# Minimum in lane 0 of a middle beat, even sign count
t_basic 3 2 e 0 3 0 0 a 4 0 d 1 0 3 b 2 a 2 2 b 2 a 2 2 a

# Minimum in lane 1, odd sign count
t_lane1_min 0 e 6 0 c b 0 2 f 0 5 c 0 1 4 1 a 1 1 9 1 9 1 9 9

# Minimum in the last beat, lane 1
t_last_beat 0 0 1 0 d 0 0 e 4 0 f 3 0 d 8 8 8 0 8 0 8 0 8 0 3

# Two equal smallest magnitudes
t_tie 0 c 2 0 1 9 0 4 f 0 6 5 0 d 3 9 1 1 9 1 9 1 1 9 1

# Back to back, all sign bits set then all clear
t_b2b_neg 0 b e 0 a d 0 f c 0 e b 0 d f a a b a a a a a a a
t_b2b_pos 0 0 0 0 2 1 0 3 2 0 0 1 0 4 3 3 3 3 3 3 3 3 3 4 3

# Same rows as t_basic and t_lane1_min with idle cycles
t_gap_basic 2 2 e 0 3 0 3 a 4 1 d 1 4 3 b 2 a 2 2 b 2 a 2 2 a
t_gap_lane1 5 e 6 1 c b 0 2 f 2 5 c 1 1 4 1 a 1 1 9 1 9 1 9 9

/* sim.f */
verilog/cnu_pkg.sv
verilog/cnu_ctrl.sv
verilog/cnu_min_track.sv
verilog/cnu_sign_track.sv
verilog/cnu_msg_gen.sv
verilog/cnu_top.sv
sim/cnu_tb.sv

/* Bender.yml */
package:
  name: cnu

sources:
  - verilog/cnu_pkg.sv
  - verilog/cnu_ctrl.sv
  - verilog/cnu_min_track.sv
  - verilog/cnu_sign_track.sv
  - verilog/cnu_msg_gen.sv
  - verilog/cnu_top.sv
  - target: simulation
    files:
      - sim/cnu_tb.sv

/* sim/cnu_tb.sv */
// Check node unit testbench
`timescale 1ns/10ps

module cnu_tb;
	import cnu_pkg::*;

	localparam int ROW_SPLIT_FACTOR = 5;
	localparam int CN_DEGREE = ROW_SPLIT_FACTOR * EXT_MSG_PARALLELISM;
	localparam int MAX_ROWS = 32;
	localparam int RESET_CYCLES = 8;

	// Output slot seen by the monitor
	// Flag present stays clear when the beat never came
	typedef struct packed {
		logic present;
		c2v_beat_t beat;
	} out_rec_t;

	logic sys_clk;
	logic rstn;
	logic in_valid;
	v2c_beat_t in_beat;
	logic out_valid;
	c2v_beat_t out_beat;

	string names [MAX_ROWS];
	int gaps [MAX_ROWS][ROW_SPLIT_FACTOR];
	logic [QUAN_SIZE-1:0] in_msgs [MAX_ROWS][CN_DEGREE];
	logic [QUAN_SIZE-1:0] exp_msgs [MAX_ROWS][CN_DEGREE];
	int num_rows;
	int max_gap;
	int cycle_limit;
	int cycle_cnt;
	int err_cnt;
	int tests_done;
	int tests_failed;
	int exp_left;
	int in_cnt;
	out_rec_t out_q [$];

	always #2 sys_clk = ~sys_clk;

	cnu_top #(
		.ROW_SPLIT_FACTOR (ROW_SPLIT_FACTOR)
	) cnu_top_inst (
		.sys_clk   (sys_clk),
		.rstn      (rstn),
		.in_valid  (in_valid),
		.in_beat   (in_beat),
		.out_valid (out_valid),
		.out_beat  (out_beat)
	);

	//////////////////////////////////////////////////////////////////////
	// Stimulus file
	//////////////////////////////////////////////////////////////////////
	task automatic read_stim();
		int fd;
		int code;
		int ch;
		int gap;
		int m0;
		int m1;
		int e;
		string tok;
		fd = $fopen("sim/cnu_stim.dat", "r");
		if (fd == 0) begin
			$display("Cannot open sim/cnu_stim.dat");
			err_cnt++;
			return;
		end
		while (num_rows < MAX_ROWS) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1)
				break;
			if (tok.getc(0) == "#") begin
				// Comment runs to the end of the line
				ch = $fgetc(fd);
				while (ch != "\n" && ch != -1)
					ch = $fgetc(fd);
			end else begin
				names[num_rows] = tok;
				for (int b = 0; b < ROW_SPLIT_FACTOR; b++) begin
					code = $fscanf(fd, "%d %h %h", gap, m0, m1);
					if (code != 3) begin
						$display("Stim row %0d has an incomplete input beat", num_rows + 1);
						err_cnt++;
						$fclose(fd);
						return;
					end
					gaps[num_rows][b] = gap;
					if (gap > max_gap)
						max_gap = gap;
					in_msgs[num_rows][2*b] = m0[QUAN_SIZE-1:0];
					in_msgs[num_rows][2*b+1] = m1[QUAN_SIZE-1:0];
				end
				for (int p = 0; p < CN_DEGREE; p++) begin
					code = $fscanf(fd, "%h", e);
					if (code != 1) begin
						$display("Stim row %0d has too few expected messages", num_rows + 1);
						err_cnt++;
						$fclose(fd);
						return;
					end
					exp_msgs[num_rows][p] = e[QUAN_SIZE-1:0];
				end
				num_rows++;
			end
		end
		$fclose(fd);
		if (num_rows == 0) begin
			$display("No test rows found in sim/cnu_stim.dat");
			err_cnt++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Driver and checker
	//////////////////////////////////////////////////////////////////////
	task automatic drive_row(int r);
		for (int b = 0; b < ROW_SPLIT_FACTOR; b++) begin
			for (int g = 0; g < gaps[r][b]; g++) begin
				@(posedge sys_clk);
				in_valid <= 1'b0;
			end
			@(posedge sys_clk);
			in_valid <= 1'b1;
			in_beat.msg_0 <= in_msgs[r][2*b];
			in_beat.msg_1 <= in_msgs[r][2*b+1];
		end
	endtask

	task automatic check_row(int r);
		out_rec_t rec;
		int bad;
		logic [QUAN_SIZE-1:0] got_val;
		logic [QUAN_SIZE-1:0] exp_val;
		bad = 0;
		for (int b = 0; b < ROW_SPLIT_FACTOR; b++) begin
			while (out_q.size() == 0)
				@(posedge sys_clk);
			rec = out_q.pop_front();
			assert (rec.present) else begin
				$display("%s: output beat %0d did not arrive on its cycle", names[r], b);
				bad++;
			end
			if (rec.present) begin
				for (int l = 0; l < EXT_MSG_PARALLELISM; l++) begin
					got_val = (l == 0) ? rec.beat.msg_0 : rec.beat.msg_1;
					exp_val = exp_msgs[r][b*EXT_MSG_PARALLELISM + l];
					assert (got_val == exp_val) else begin
						$display("MISMATCH %s msg %0d: expected %h, actual %h", names[r],
							b*EXT_MSG_PARALLELISM + l, exp_val, got_val);
						bad++;
					end
				end
			end
		end
		err_cnt += bad;
		tests_done++;
		if (bad == 0) begin
			$display("PASS %s", names[r]);
		end else begin
			$display("FAIL %s with %0d errors", names[r], bad);
			tests_failed++;
		end
	endtask

	task automatic report_counts();
		$display("Tests run %0d, tests failed %0d, errors %0d", tests_done, tests_failed,
			err_cnt);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////////////////////////
	// Burst is due on the cycles right after the last input beat of a row
	always @(posedge sys_clk) begin
		if (rstn) begin
			if (out_valid) begin
				assert (exp_left > 0) else begin
					$display("Extra output beat while no row result was due");
					err_cnt++;
				end
				if (exp_left > 0) begin
					out_q.push_back('{present: 1'b1, beat: out_beat});
					exp_left--;
				end
			end else if (exp_left > 0) begin
				out_q.push_back('{present: 1'b0, beat: '0});
				exp_left--;
			end
			if (in_valid) begin
				if (in_cnt == ROW_SPLIT_FACTOR - 1) begin
					in_cnt = 0;
					exp_left += ROW_SPLIT_FACTOR;
				end else begin
					in_cnt++;
				end
			end
		end
	end

	// Run limit
	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout after %0d cycles with output beats still outstanding", cycle_cnt);
			report_counts();
			$display("Some tests failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		sys_clk = 1'b0;
		rstn = 1'b0;
		in_valid = 1'b0;
		in_beat = '0;
		cycle_cnt = 0;
		err_cnt = 0;
		tests_done = 0;
		tests_failed = 0;
		exp_left = 0;
		in_cnt = 0;
		num_rows = 0;
		max_gap = 0;
		read_stim();
		cycle_limit = num_rows * (3 * ROW_SPLIT_FACTOR + max_gap) + 100;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		rstn <= 1'b1;
		if (err_cnt == 0) begin
			fork
				begin
					for (int r = 0; r < num_rows; r++)
						drive_row(r);
					@(posedge sys_clk);
					in_valid <= 1'b0;
				end
				begin
					for (int r = 0; r < num_rows; r++)
						check_row(r);
				end
			join
			// Idle tail to catch stray beats
			repeat (2 * ROW_SPLIT_FACTOR) @(posedge sys_clk);
		end
		report_counts();
		if (err_cnt == 0 && tests_failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* verilog/cnu_top.sv */
// Row-split min-sum check node unit
`timescale 1ns/10ps

module cnu_top #(
	parameter int ROW_SPLIT_FACTOR = 5
) (
	input logic sys_clk,
	input logic rstn,
	input logic in_valid,
	input cnu_pkg::v2c_beat_t in_beat,
	output logic out_valid,
	output cnu_pkg::c2v_beat_t out_beat
);
	import cnu_pkg::*;

	logic first_beat;
	logic row_end;
	logic [BEAT_IDX_SIZE-1:0] in_idx;
	logic [BEAT_IDX_SIZE-1:0] out_idx;
	row_summary_t summary;
	logic [ROW_SPLIT_FACTOR*EXT_MSG_PARALLELISM-1:0] signs;
	logic parity;

	//////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////
	cnu_ctrl #(
		.ROW_SPLIT_FACTOR (ROW_SPLIT_FACTOR)
	) cnu_ctrl_inst (
		.sys_clk    (sys_clk),
		.rstn       (rstn),
		.in_valid   (in_valid),
		.first_beat (first_beat),
		.row_end    (row_end),
		.in_idx     (in_idx),
		.out_valid  (out_valid),
		.out_idx    (out_idx)
	);

	//////////////////////////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////////////////////////
	cnu_min_track #(
		.ROW_SPLIT_FACTOR (ROW_SPLIT_FACTOR)
	) cnu_min_track_inst (
		.sys_clk    (sys_clk),
		.rstn       (rstn),
		.in_valid   (in_valid),
		.first_beat (first_beat),
		.row_end    (row_end),
		.in_idx     (in_idx),
		.in_beat    (in_beat),
		.summary    (summary)
	);

	cnu_sign_track #(
		.ROW_SPLIT_FACTOR (ROW_SPLIT_FACTOR)
	) cnu_sign_track_inst (
		.sys_clk    (sys_clk),
		.rstn       (rstn),
		.in_valid   (in_valid),
		.first_beat (first_beat),
		.row_end    (row_end),
		.in_idx     (in_idx),
		.in_beat    (in_beat),
		.signs      (signs),
		.parity     (parity)
	);

	// Reads the snapshot of the previous row during its burst
	cnu_msg_gen #(
		.ROW_SPLIT_FACTOR (ROW_SPLIT_FACTOR)
	) cnu_msg_gen_inst (
		.summary  (summary),
		.signs    (signs),
		.parity   (parity),
		.out_idx  (out_idx),
		.out_beat (out_beat)
	);

endmodule

/* verilog/cnu_msg_gen.sv */
// Check-to-variable message builder
`timescale 1ns/10ps

module cnu_msg_gen #(
	parameter int ROW_SPLIT_FACTOR = 5
) (
	input cnu_pkg::row_summary_t summary,
	input logic [ROW_SPLIT_FACTOR*cnu_pkg::EXT_MSG_PARALLELISM-1:0] signs,
	input logic parity,
	input logic [cnu_pkg::BEAT_IDX_SIZE-1:0] out_idx,
	output cnu_pkg::c2v_beat_t out_beat
);
	import cnu_pkg::*;

	logic [EXT_MSG_PARALLELISM-1:0] beat_signs;
	pos_t pos_0;
	pos_t pos_1;

	// The minimum position itself gets the second minimum
	function automatic sm_msg_t build_msg(row_summary_t s, pos_t pos, logic sgn);
		sm_msg_t m;
		m.sign = sgn;
		m.mag = (pos == s.min_pos) ? s.min_1 : s.min_0;
		return m;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Sign pair of the current output beat
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		beat_signs = '0;
		for (int b = 0; b < ROW_SPLIT_FACTOR; b++) begin
			if (out_idx == BEAT_IDX_SIZE'(b))
				beat_signs = signs[b*EXT_MSG_PARALLELISM +: EXT_MSG_PARALLELISM];
		end
	end

	assign pos_0 = {out_idx, 1'b0};
	assign pos_1 = {out_idx, 1'b1};

	// Own sign xor row parity leaves the product of the other signs
	assign out_beat.msg_0 = build_msg(summary, pos_0, beat_signs[0] ^ parity);
	assign out_beat.msg_1 = build_msg(summary, pos_1, beat_signs[1] ^ parity);

endmodule

/* verilog/cnu_sign_track.sv */
// Sign record and parity tracker
`timescale 1ns/10ps

module cnu_sign_track #(
	parameter int ROW_SPLIT_FACTOR = 5
) (
	input logic sys_clk,
	input logic rstn,
	input logic in_valid,
	input logic first_beat,
	input logic row_end,
	input logic [cnu_pkg::BEAT_IDX_SIZE-1:0] in_idx,
	input cnu_pkg::v2c_beat_t in_beat,
	output logic [ROW_SPLIT_FACTOR*cnu_pkg::EXT_MSG_PARALLELISM-1:0] signs,
	output logic parity
);
	import cnu_pkg::*;

	localparam int REC_W = ROW_SPLIT_FACTOR * EXT_MSG_PARALLELISM;

	logic [EXT_MSG_PARALLELISM-1:0] beat_signs;
	logic [REC_W-1:0] sign_rec;
	logic [REC_W-1:0] sign_next;
	logic par_run;
	logic par_next;

	assign beat_signs = {in_beat.msg_1[SIGN_BIT], in_beat.msg_0[SIGN_BIT]};
	assign par_next = first_beat ? ^beat_signs : (par_run ^ (^beat_signs));

	// Drop the new pair into its beat slot
	always_comb begin
		sign_next = sign_rec;
		for (int b = 0; b < ROW_SPLIT_FACTOR; b++) begin
			if (in_idx == BEAT_IDX_SIZE'(b))
				sign_next[b*EXT_MSG_PARALLELISM +: EXT_MSG_PARALLELISM] = beat_signs;
		end
	end

	// Sign record of the row in progress
	always_ff @(posedge sys_clk) begin
		if (!rstn)
			sign_rec <= '0;
		else if (in_valid)
			sign_rec <= sign_next;
	end

	always_ff @(posedge sys_clk) begin
		if (!rstn)
			par_run <= 1'b0;
		else if (in_valid)
			par_run <= par_next;
	end

	//////////////////////////////////////////////////////////////////////
	// Holding registers for the output burst
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk) begin
		if (!rstn) begin
			signs <= '0;
			parity <= 1'b0;
		end else if (row_end) begin
			signs <= sign_next;
			parity <= par_next;
		end
	end

endmodule

/* verilog/cnu_min_track.sv */
// Running minimum tracker
`timescale 1ns/10ps

module cnu_min_track #(
	parameter int ROW_SPLIT_FACTOR = 5
) (
	input logic sys_clk,
	input logic rstn,
	input logic in_valid,
	input logic first_beat,
	input logic row_end,
	input logic [cnu_pkg::BEAT_IDX_SIZE-1:0] in_idx,
	input cnu_pkg::v2c_beat_t in_beat,
	output cnu_pkg::row_summary_t summary
);
	import cnu_pkg::*;

	localparam int CN_DEGREE = ROW_SPLIT_FACTOR * EXT_MSG_PARALLELISM;

	logic [MAG_SIZE-1:0] mag_0;
	logic [MAG_SIZE-1:0] mag_1;
	pos_t pos_0;
	pos_t pos_1;
	row_summary_t seed;
	row_summary_t base;
	row_summary_t next_sum;
	row_summary_t run_sum;

	// Sign bit set keeps the low bits, clear inverts them
	function automatic logic [MAG_SIZE-1:0] to_mag(logic [QUAN_SIZE-1:0] msg);
		return msg[SIGN_BIT] ? msg[MAG_SIZE-1:0] : ~msg[MAG_SIZE-1:0];
	endfunction

	// Strict compares, so ties keep the earlier position
	function automatic row_summary_t insert_mag(row_summary_t s, logic [MAG_SIZE-1:0] mag,
			pos_t pos);
		row_summary_t r;
		r = s;
		if (mag < s.min_0) begin
			r.min_0 = mag;
			r.min_1 = s.min_0;
			r.min_pos = pos;
		end else if (mag < s.min_1) begin
			r.min_1 = mag;
		end
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Conversion and compare-select
	//////////////////////////////////////////////////////////////////////
	assign mag_0 = to_mag(in_beat.msg_0);
	assign mag_1 = to_mag(in_beat.msg_1);
	assign pos_0 = {in_idx, 1'b0};
	assign pos_1 = {in_idx, 1'b1};

	always_comb begin
		seed = '{min_0: mag_0, min_1: MAG_MAX, min_pos: pos_0};
		// First beat ignores the feedback entirely
		if (first_beat)
			base = seed;
		else
			base = insert_mag(run_sum, mag_0, pos_0);
		next_sum = insert_mag(base, mag_1, pos_1);
	end

	//////////////////////////////////////////////////////////////////////
	// Running and holding registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk) begin
		if (!rstn)
			run_sum <= '0;
		else if (in_valid)
			run_sum <= next_sum;
	end

	// Includes the beat that closes the row
	always_ff @(posedge sys_clk) begin
		if (!rstn)
			summary <= '0;
		else if (row_end)
			summary <= next_sum;
	end

	a_min_order: assert property (@(posedge sys_clk) disable iff (!rstn)
		run_sum.min_0 <= run_sum.min_1);

	a_min_pos_range: assert property (@(posedge sys_clk) disable iff (!rstn)
		summary.min_pos < CN_DEGREE);

endmodule

/* verilog/cnu_ctrl.sv */
// Check node beat control
`timescale 1ns/10ps

module cnu_ctrl #(
	parameter int ROW_SPLIT_FACTOR = 5
) (
	input logic sys_clk,
	input logic rstn,
	input logic in_valid,
	output logic first_beat,
	output logic row_end,
	output logic [cnu_pkg::BEAT_IDX_SIZE-1:0] in_idx,
	output logic out_valid,
	output logic [cnu_pkg::BEAT_IDX_SIZE-1:0] out_idx
);
	import cnu_pkg::*;

	localparam logic [BEAT_IDX_SIZE-1:0] LAST_IDX = BEAT_IDX_SIZE'(ROW_SPLIT_FACTOR - 1);

	if (ROW_SPLIT_FACTOR < 1 || ROW_SPLIT_FACTOR > MAX_ROW_SPLIT) begin : g_split_check
		$error("ROW_SPLIT_FACTOR outside 1..%0d", MAX_ROW_SPLIT);
	end

	logic [BEAT_IDX_SIZE-1:0] beat_cnt;

	//////////////////////////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////////////////////////
	assign in_idx = beat_cnt;
	assign first_beat = in_valid && (beat_cnt == '0);
	assign row_end = in_valid && (beat_cnt == LAST_IDX);

	always_ff @(posedge sys_clk) begin
		if (!rstn) begin
			beat_cnt <= '0;
		end else if (in_valid) begin
			if (beat_cnt == LAST_IDX)
				beat_cnt <= '0;
			else
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output burst sequencer
	//////////////////////////////////////////////////////////////////////
	// A new row end may coincide with the last beat of the running burst
	always_ff @(posedge sys_clk) begin
		if (!rstn) begin
			out_valid <= 1'b0;
			out_idx <= '0;
		end else if (row_end) begin
			out_valid <= 1'b1;
			out_idx <= '0;
		end else if (out_valid) begin
			if (out_idx == LAST_IDX) begin
				out_valid <= 1'b0;
				out_idx <= '0;
			end else begin
				out_idx <= out_idx + 1'b1;
			end
		end
	end

	// Burst index stays inside the row
	a_out_idx_range: assert property (@(posedge sys_clk) disable iff (!rstn)
		out_valid |-> (out_idx < ROW_SPLIT_FACTOR));

	// Snapshot must not overwrite the holding registers mid-burst
	a_no_early_row_end: assert property (@(posedge sys_clk) disable iff (!rstn)
		row_end |-> (!out_valid || out_idx == LAST_IDX));

endmodule

/* verilog/cnu_pkg.sv */
// Check node unit shared definitions
package cnu_pkg;

	////////////////////////////////////////////////////////////////////////
	// Message widths
	////////////////////////////////////////////////////////////////////////
	localparam int QUAN_SIZE = 4;
	localparam int MAG_SIZE = 3;
	localparam int EXT_MSG_PARALLELISM = 2;
	localparam int MAX_ROW_SPLIT = 16;
	localparam int POS_SIZE = 5;
	localparam int BEAT_IDX_SIZE = 4;

	// Sign-magnitude helpers
	localparam int SIGN_BIT = QUAN_SIZE - 1;
	localparam logic [MAG_SIZE-1:0] MAG_MAX = {MAG_SIZE{1'b1}};

	// Message position within a row
	typedef logic [POS_SIZE-1:0] pos_t;

	////////////////////////////////////////////////////////////////////////
	// Beat and summary structs
	////////////////////////////////////////////////////////////////////////
	// Lane 0 sits in the low nibble
	typedef struct packed {
		logic [QUAN_SIZE-1:0] msg_1;
		logic [QUAN_SIZE-1:0] msg_0;
	} v2c_beat_t;

	typedef struct packed {
		logic sign;
		logic [MAG_SIZE-1:0] mag;
	} sm_msg_t;

	typedef struct packed {
		sm_msg_t msg_1;
		sm_msg_t msg_0;
	} c2v_beat_t;

	// First and second minimum with position of the first
	typedef struct packed {
		logic [MAG_SIZE-1:0] min_0;
		logic [MAG_SIZE-1:0] min_1;
		pos_t min_pos;
	} row_summary_t;

endpackage
